//--- common/cpuPkg.sv
`include "cpu_defines.svh"

package cpuPkg;

    typedef enum logic [4:0] {
        aluAdd, aluAddu, aluSub, aluSubu, aluAnd, aluOr, aluXor, aluNor,
        aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui,
        aluMult, aluMultu, aluDiv, aluDivu, aluMadd
    } AluOp;

    typedef enum logic [2:0] {
        brNone, brBeq, brBne, brBgez, brBltz, brBlez, brBgtz, brJr
    } BranchType;

    typedef enum logic [1:0] {ldNone, ldByte, ldHalf, ldWord} LoadType;
    typedef enum logic [1:0] {stNone, stByte, stHalf, stWord} StoreType;

    typedef enum logic [1:0] {wbPcPlus8, wbAluOut, wbOutB} WbSel;
    typedef enum logic [1:0] {dstRd, dstRt, dstR31} DstSel;
    typedef enum logic [1:0] {readBusB, readHi, readLo} RegsReadSel;

    typedef struct packed {
        logic gprWr;
        logic hiWr;
        logic loWr;
    } RegsWrType;

    typedef struct packed {
        logic syscall;
        logic breakpoint;
        logic reserved;
        logic overflow;
        logic addrErrLoad;
        logic addrErrStore;
    } ExceptType;

    // same instruction word, R-format and I-format fields
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rView;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } iView;
    } InstrWord;

    typedef struct packed {
        logic                   predTaken;
        logic [`DATA_WIDTH-1:0] predTarget;
    } PResult;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] busA;
        logic [`DATA_WIDTH-1:0] busB;
        logic [`DATA_WIDTH-1:0] imm32;
        logic [`DATA_WIDTH-1:0] pc;
        InstrWord               instr;
        AluOp                   aluOp;
        logic                   aluSrcA;     // 1 selects shamt
        logic                   aluSrcB;     // 1 selects imm32
        DstSel                  dstSel;
        WbSel                   wbSel;
        RegsReadSel             regsReadSel;
        RegsWrType              regsWr;
        LoadType                loadType;
        StoreType               storeType;
        BranchType              branchType;
        ExceptType              exceptIn;
        PResult                 pResult;
    } IdExeBus;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] pc;
        InstrWord               instr;
        logic [`DATA_WIDTH-1:0] aluOut;
        logic [`DATA_WIDTH-1:0] outB;
        logic [`DATA_WIDTH-1:0] result;
        logic [4:0]             dst;
        WbSel                   wbSel;
        RegsWrType              regsWr;
        LoadType                loadType;
        StoreType               storeType;
        ExceptType              except;
    } ExeMemBus;

endpackage

//--- common/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// machine word
`define DATA_WIDTH 32

// multiply occupies the unit for this many cycles
// (start cycle not counted, finish lands on the last one)
`define MULT_CYCLES 3

// restoring divider, one quotient bit per cycle
`define DIV_CYCLES 32

`endif

//--- compile.f
+incdir+common
common/cpuPkg.sv
exe/exeReg.sv
exe/alu.sv
exe/branchSolve.sv
multDiv/multDiv.sv
verilog/hiLo.sv
verilog/exceptionInExe.sv
exe/topExe.sv
testbench/tbTopExe.sv

//--- exe/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpuPkg::IdExeBus exeState,
    output logic [31:0]     aluOut,
    output logic            overflow
);
    import cpuPkg::*;

    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [31:0] sum;
    logic [31:0] diff;
    logic        instrValid;

    assign srcA = exeState.aluSrcA ? {27'b0, exeState.instr.rView.shamt} : exeState.busA;
    assign srcB = exeState.aluSrcB ? exeState.imm32 : exeState.busB;

    assign sum  = srcA + srcB;
    assign diff = srcA - srcB;

    always_comb begin
        overflow = 1'b0;
        case (exeState.aluOp)
            aluAdd: begin
                aluOut   = sum;
                overflow = (srcA[31] == srcB[31]) && (sum[31] != srcA[31]);
            end
            aluAddu: aluOut = sum;
            aluSub: begin
                aluOut   = diff;
                overflow = (srcA[31] != srcB[31]) && (diff[31] != srcA[31]);
            end
            aluSubu: aluOut = diff;
            aluAnd:  aluOut = srcA & srcB;
            aluOr:   aluOut = srcA | srcB;
            aluXor:  aluOut = srcA ^ srcB;
            aluNor:  aluOut = ~(srcA | srcB);
            aluSlt:  aluOut = {31'b0, $signed(srcA) < $signed(srcB)};
            aluSltu: aluOut = {31'b0, srcA < srcB};
            aluSll:  aluOut = srcB << srcA[4:0];
            aluSrl:  aluOut = srcB >> srcA[4:0];
            aluSra:  aluOut = $unsigned($signed(srcB) >>> srcA[4:0]);
            aluLui:  aluOut = {srcB[15:0], 16'b0};
            default: aluOut = sum;                     // mult/div ops, result unused
        endcase
    end

    // anything that commits state must arrive with a decoded op
    assign instrValid = (exeState.regsWr != '0) || (exeState.loadType != ldNone)
                        || (exeState.storeType != stNone);

    aluOpKnown: assert property (
        @(exeState) instrValid |-> !$isunknown(exeState.aluOp)
    );

endmodule

//--- exe/branchSolve.sv
`timescale 1ns/1ps

module branchSolve (
    input  cpuPkg::IdExeBus exeState,
    output logic            isTaken,
    output logic            predictionFailed,
    output logic [31:0]     correctionVector
);
    import cpuPkg::*;

    logic [31:0] pcPlus4;
    logic [31:0] pcPlus8;
    logic [31:0] target;
    logic        aZero;
    logic        aNeg;
    logic        wrongDir;
    logic        wrongTarget;

    assign pcPlus4 = exeState.pc + 32'd4;
    assign pcPlus8 = exeState.pc + 32'd8;
    assign aZero   = (exeState.busA == 32'b0);
    assign aNeg    = exeState.busA[31];

    always_comb begin
        case (exeState.branchType)
            brBeq:   isTaken = (exeState.busA == exeState.busB);
            brBne:   isTaken = (exeState.busA != exeState.busB);
            brBgez:  isTaken = !aNeg;
            brBltz:  isTaken = aNeg;
            brBlez:  isTaken = aNeg || aZero;
            brBgtz:  isTaken = !aNeg && !aZero;
            brJr:    isTaken = 1'b1;
            default: isTaken = 1'b0;
        endcase
    end

    // jr jumps to rs, branches are relative to the delay slot
    assign target = (exeState.branchType == brJr) ? exeState.busA
                                                  : pcPlus4 + {exeState.imm32[29:0], 2'b00};

    assign wrongDir    = exeState.pResult.predTaken != isTaken;
    assign wrongTarget = isTaken && exeState.pResult.predTaken
                         && (exeState.pResult.predTarget != target);

    assign predictionFailed = (exeState.branchType != brNone) && (wrongDir || wrongTarget);
    assign correctionVector = isTaken ? target : pcPlus8;  // not taken resumes after slot

endmodule

//--- exe/exeReg.sv
`timescale 1ns/1ps

module exeReg (
    input  logic             clk,
    input  logic             rstN,
    input  logic             exeFlush,
    input  logic             exeWr,
    input  cpuPkg::IdExeBus  idExe,
    output cpuPkg::IdExeBus  exeState
);
    import cpuPkg::*;

    IdExeBus bubble;

    // nop: nothing written, no memory access, no branch
    always_comb begin
        bubble            = '0;
        bubble.aluOp      = aluAdd;
        bubble.branchType = brNone;
        bubble.loadType   = ldNone;
        bubble.storeType  = stNone;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exeState <= bubble;
        end else if (exeFlush) begin    // flush wins over write
            exeState <= bubble;
        end else if (exeWr) begin
            exeState <= idExe;
        end
    end

    // a flushed slot must never write the register file or HI/LO
    flushKillsWrites: assert property (
        @(posedge clk) disable iff (!rstN)
        exeFlush |=> (exeState.regsWr == '0)
    );

endmodule

//--- exe/topExe.sv
`timescale 1ns/1ps

module topExe (
    input  logic              clk,
    input  logic              rstN,
    input  logic              exeFlush,
    input  logic              exeWr,
    input  cpuPkg::IdExeBus   idExe,
    output cpuPkg::ExeMemBus  exeMem,
    output logic              predictionFailed,
    output logic [31:0]       correctionVector,
    output logic              isTaken,
    output logic              multDivStall
);
    import cpuPkg::*;

    IdExeBus     exeState;
    logic [31:0] aluOut;
    logic        overflow;
    logic [31:0] multHi;
    logic [31:0] multLo;
    logic        finish;
    logic        accumulate;
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] outB;
    logic [31:0] result;
    logic [4:0]  dst;
    logic        hiWr;
    logic        loWr;

    // mthi/mtlo commit once, on the edge that moves the instruction on
    assign hiWr = exeWr && exeState.regsWr.hiWr;
    assign loWr = exeWr && exeState.regsWr.loWr;

    exeReg uExeReg (
        .clk      (clk),
        .rstN     (rstN),
        .exeFlush (exeFlush),
        .exeWr    (exeWr),
        .idExe    (idExe),
        .exeState (exeState)
    );

    alu uAlu (
        .exeState (exeState),
        .aluOut   (aluOut),
        .overflow (overflow)
    );

    branchSolve uBranchSolve (
        .exeState         (exeState),
        .isTaken          (isTaken),
        .predictionFailed (predictionFailed),
        .correctionVector (correctionVector)
    );

    multDiv uMultDiv (
        .clk        (clk),
        .rstN       (rstN),
        .exeFlush   (exeFlush),
        .exeState   (exeState),
        .multHi     (multHi),
        .multLo     (multLo),
        .finish     (finish),
        .stall      (multDivStall),
        .accumulate (accumulate)
    );

    hiLo uHiLo (
        .clk        (clk),
        .rstN       (rstN),
        .finish     (finish),
        .accumulate (accumulate),
        .hiWr       (hiWr),
        .loWr       (loWr),
        .writeData  (exeState.busA),
        .multHi     (multHi),
        .multLo     (multLo),
        .hi         (hi),
        .lo         (lo)
    );

    exceptionInExe uExceptionInExe (
        .exceptIn  (exeState.exceptIn),
        .overflow  (overflow),
        .loadType  (exeState.loadType),
        .storeType (exeState.storeType),
        .addrLow   (aluOut[1:0]),
        .except    (exeMem.except)
    );

    always_comb begin
        case (exeState.regsReadSel)
            readHi:  outB = hi;
            readLo:  outB = lo;
            default: outB = exeState.busB;
        endcase
        case (exeState.wbSel)
            wbPcPlus8: result = exeState.pc + 32'd8;   // link address
            wbAluOut:  result = aluOut;
            default:   result = outB;
        endcase
        case (exeState.dstSel)
            dstRd:   dst = exeState.instr.rView.rd;
            dstRt:   dst = exeState.instr.iView.rt;
            default: dst = 5'd31;
        endcase
    end

    assign exeMem.pc        = exeState.pc;
    assign exeMem.instr     = exeState.instr;
    assign exeMem.aluOut    = aluOut;
    assign exeMem.outB      = outB;
    assign exeMem.result    = result;
    assign exeMem.dst       = dst;
    assign exeMem.wbSel     = exeState.wbSel;
    assign exeMem.regsWr    = exeState.regsWr;
    assign exeMem.loadType  = exeState.loadType;
    assign exeMem.storeType = exeState.storeType;

endmodule

//--- multDiv/multDiv.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module multDiv (
    input  logic            clk,
    input  logic            rstN,
    input  logic            exeFlush,
    input  cpuPkg::IdExeBus exeState,
    output logic [31:0]     multHi,
    output logic [31:0]     multLo,
    output logic            finish,
    output logic            stall,
    output logic            accumulate
);
    import cpuPkg::*;

    localparam int CntW = $clog2(`DIV_CYCLES + 1);

    logic               isMdOp;
    logic               isDivOp;
    logic               isSignedOp;
    logic               start;
    logic               busy;
    logic [CntW-1:0]    cnt;
    logic               opDiv;
    logic               opMadd;
    logic               quoNeg;
    logic               remNeg;
    logic signed [32:0] mulA;
    logic signed [32:0] mulB;
    logic signed [65:0] product;
    logic [31:0]        absA;
    logic [31:0]        absB;
    logic [31:0]        remReg;
    logic [31:0]        quoReg;
    logic [31:0]        divisor;
    logic [31:0]        stepRem;
    logic [31:0]        stepQuo;
    logic [31:0]        stepDivisor;
    logic [32:0]        shifted;
    logic [32:0]        trial;

    assign isMdOp     = exeState.aluOp inside {aluMult, aluMultu, aluDiv, aluDivu, aluMadd};
    assign isDivOp    = exeState.aluOp inside {aluDiv, aluDivu};
    assign isSignedOp = exeState.aluOp inside {aluMult, aluDiv, aluMadd};

    assign start  = isMdOp && !busy;
    assign finish = busy && (cnt == (opDiv ? CntW'(`DIV_CYCLES) : CntW'(`MULT_CYCLES)));
    assign stall  = start || (busy && !finish);  // drops in the finish cycle

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (exeFlush) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= CntW'(1);
        end else if (finish) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (busy) begin
            cnt <= cnt + CntW'(1);
        end
    end

    // divider works on magnitudes and fixes the signs at the output
    assign absA = (isSignedOp && exeState.busA[31]) ? -exeState.busA : exeState.busA;
    assign absB = (isSignedOp && exeState.busB[31]) ? -exeState.busB : exeState.busB;

    // first quotient bit is taken on the start edge itself
    assign stepRem     = busy ? remReg : 32'b0;
    assign stepQuo     = busy ? quoReg : absA;
    assign stepDivisor = busy ? divisor : absB;

    assign shifted = {stepRem, stepQuo[31]};
    assign trial   = shifted - {1'b0, stepDivisor};   // bit 32 set means borrow

    always_ff @(posedge clk) begin
        if (start) begin
            opDiv   <= isDivOp;
            opMadd  <= (exeState.aluOp == aluMadd);
            mulA    <= {isSignedOp & exeState.busA[31], exeState.busA};
            mulB    <= {isSignedOp & exeState.busB[31], exeState.busB};
            divisor <= absB;
            // x/0 keeps the all-ones quotient
            quoNeg  <= isSignedOp && (exeState.busA[31] ^ exeState.busB[31])
                       && (exeState.busB != 32'b0);
            remNeg  <= isSignedOp && exeState.busA[31];
        end
        if (start || (busy && !finish)) begin
            remReg <= trial[32] ? shifted[31:0] : trial[31:0];
            quoReg <= {stepQuo[30:0], ~trial[32]};
        end
    end

    assign product = mulA * mulB;

    always_comb begin
        if (opDiv) begin
            multHi = remNeg ? -remReg : remReg;
            multLo = quoNeg ? -quoReg : quoReg;
        end else begin
            multHi = product[63:32];
            multLo = product[31:0];
        end
    end

    assign accumulate = opMadd;

    // restoring division always ends with a remainder below the divisor
    remBelowDivisor: assert property (
        @(posedge clk) disable iff (!rstN)
        finish && opDiv && (divisor != 32'b0) |-> (remReg < divisor)
    );

endmodule

//--- testbench/tbTopExe.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module tbTopExe;
    import cpuPkg::*;

    typedef struct packed {
        ExeMemBus    mem;
        logic        taken;
        logic        predFail;
        logic [31:0] corr;
    } ExpectType;

    logic        clk;
    logic        rstN;
    logic        exeFlush;
    logic        exeWr;
    IdExeBus     idExe;
    ExeMemBus    exeMem;
    logic        predictionFailed;
    logic [31:0] correctionVector;
    logic        isTaken;
    logic        multDivStall;

    logic [31:0] lcgState = 32'd96789;
    logic [31:0] shadowHi = '0;
    logic [31:0] shadowLo = '0;
    logic        pendHi = 1'b0;   // held mthi/mtlo commits on the next load
    logic        pendLo = 1'b0;
    logic [31:0] pendData = '0;
    ExpectType   expected;
    int          checkMode;       // 0 idle, 1 full compare, 2 bubble

    topExe dut0 (
        .clk              (clk),
        .rstN             (rstN),
        .exeFlush         (exeFlush),
        .exeWr            (exeWr),
        .idExe            (idExe),
        .exeMem           (exeMem),
        .predictionFailed (predictionFailed),
        .correctionVector (correctionVector),
        .isTaken          (isTaken),
        .multDivStall     (multDivStall)
    );

    always #2 clk = ~clk;

    // two LCG steps give the upper halves of both
    function automatic logic [31:0] nextRand();
        logic [15:0] upper;
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        upper = lcgState[31:16];
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return {upper, lcgState[31:16]};
    endfunction

    function automatic logic [31:0] branchTarget(input IdExeBus s);
        if (s.branchType == brJr)
            return s.busA;
        return s.pc + 32'd4 + (s.imm32 << 2);
    endfunction

    function automatic IdExeBus randomInstr(input bit withBranch);
        IdExeBus     s;
        logic [31:0] r;
        logic [31:0] r2;
        r = nextRand();
        s.busA  = (r[7:4] == 4'd0) ? 32'd0 : nextRand();
        s.busB  = (r[3:0] == 4'd0) ? s.busA : nextRand();   // equal now and then for beq
        s.imm32 = {{16{r[31]}}, r[31:16]};
        r = nextRand();
        s.pc    = {r[31:2], 2'b00};
        s.instr = nextRand();
        r = nextRand();
        s.aluOp       = AluOp'(r[4:0] % 5'd14);
        s.aluSrcA     = r[8];
        s.aluSrcB     = r[9];
        s.dstSel      = DstSel'(r[11:10] % 2'd3);
        s.wbSel       = WbSel'(r[13:12] % 2'd3);
        s.regsReadSel = RegsReadSel'(r[15:14] % 2'd3);
        s.regsWr      = r[18:16];
        s.loadType    = LoadType'(r[20:19]);
        s.storeType   = StoreType'(r[22:21]);
        s.branchType  = withBranch ? BranchType'(r[25:23]) : brNone;
        r2 = nextRand();
        s.exceptIn = (r2[2:0] == 3'd0) ? r2[8:3] : '0;
        s.pResult.predTaken  = r2[9];
        s.pResult.predTarget = r2[10] ? branchTarget(s) : nextRand();
        return s;
    endfunction

    function automatic ExpectType refExe(input IdExeBus s, input logic [31:0] hiVal,
                                         input logic [31:0] loVal);
        ExpectType   e;
        logic [31:0] a;
        logic [31:0] b;
        logic [32:0] wide;
        logic [31:0] target;
        e = '0;
        a = s.aluSrcA ? {27'd0, s.instr.rView.shamt} : s.busA;
        b = s.aluSrcB ? s.imm32 : s.busB;
        case (s.aluOp)
            aluAdd, aluAddu: e.mem.aluOut = a + b;
            aluSub, aluSubu: e.mem.aluOut = a - b;
            aluAnd:  e.mem.aluOut = a & b;
            aluOr:   e.mem.aluOut = a | b;
            aluXor:  e.mem.aluOut = a ^ b;
            aluNor:  e.mem.aluOut = ~(a | b);
            aluSlt:  e.mem.aluOut = {31'd0, $signed(a) < $signed(b)};
            aluSltu: e.mem.aluOut = {31'd0, a < b};
            aluSll:  e.mem.aluOut = b << a[4:0];
            aluSrl:  e.mem.aluOut = b >> a[4:0];
            aluSra:  e.mem.aluOut = $signed(b) >>> a[4:0];
            default: e.mem.aluOut = {b[15:0], 16'd0};   // lui
        endcase
        e.mem.except = s.exceptIn;
        if (s.aluOp == aluAdd || s.aluOp == aluSub) begin
            wide = (s.aluOp == aluAdd) ? {a[31], a} + {b[31], b} : {a[31], a} - {b[31], b};
            e.mem.except.overflow = s.exceptIn.overflow | (wide[32] != wide[31]);
        end
        if ((s.loadType == ldWord && e.mem.aluOut[1:0] != 2'd0)
                || (s.loadType == ldHalf && e.mem.aluOut[0]))
            e.mem.except.addrErrLoad = 1'b1;
        if ((s.storeType == stWord && e.mem.aluOut[1:0] != 2'd0)
                || (s.storeType == stHalf && e.mem.aluOut[0]))
            e.mem.except.addrErrStore = 1'b1;
        e.mem.outB = (s.regsReadSel == readHi) ? hiVal :
                     (s.regsReadSel == readLo) ? loVal : s.busB;
        e.mem.result = (s.wbSel == wbPcPlus8) ? s.pc + 32'd8 :
                       (s.wbSel == wbAluOut) ? e.mem.aluOut : e.mem.outB;
        e.mem.dst = (s.dstSel == dstRd) ? s.instr[15:11] :
                    (s.dstSel == dstRt) ? s.instr[20:16] : 5'd31;
        e.mem.pc        = s.pc;
        e.mem.instr     = s.instr;
        e.mem.wbSel     = s.wbSel;
        e.mem.regsWr    = s.regsWr;
        e.mem.loadType  = s.loadType;
        e.mem.storeType = s.storeType;
        case (s.branchType)
            brBeq:   e.taken = (s.busA == s.busB);
            brBne:   e.taken = (s.busA != s.busB);
            brBgez:  e.taken = ($signed(s.busA) >= 0);
            brBltz:  e.taken = ($signed(s.busA) < 0);
            brBlez:  e.taken = ($signed(s.busA) <= 0);
            brBgtz:  e.taken = ($signed(s.busA) > 0);
            brJr:    e.taken = 1'b1;
            default: e.taken = 1'b0;
        endcase
        target = branchTarget(s);
        e.predFail = (s.branchType != brNone) && ((s.pResult.predTaken != e.taken)
                     || (e.taken && s.pResult.predTarget != target));
        e.corr = e.taken ? target : s.pc + 32'd8;
        return e;
    endfunction

    // {hi, lo} after a multiply/divide op
    function automatic logic [63:0] mdRef(input AluOp op, input logic [31:0] a,
                                          input logic [31:0] b, input logic [31:0] hiVal,
                                          input logic [31:0] loVal);
        logic [63:0] sProd;
        logic [31:0] quo;
        logic [31:0] rem;
        sProd = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        if (op == aluMult)
            return sProd;
        if (op == aluMultu)
            return {32'd0, a} * {32'd0, b};
        if (op == aluMadd)
            return {hiVal, loVal} + sProd;
        if (b == 32'd0)
            return {a, 32'hffffffff};   // x/0 keeps dividend in hi
        if (op == aluDiv) begin
            quo = $signed(a) / $signed(b);
            rem = $signed(a) % $signed(b);
        end else begin
            quo = a / b;
            rem = a % b;
        end
        return {rem, quo};
    endfunction

    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    always @(negedge clk) begin
        if (checkMode == 1) begin
            checkValue("exeMem.aluOut", exeMem.aluOut, expected.mem.aluOut);
            checkValue("exeMem.outB", exeMem.outB, expected.mem.outB);
            checkValue("exeMem.result", exeMem.result, expected.mem.result);
            checkValue("exeMem.dst", exeMem.dst, expected.mem.dst);
            checkValue("exeMem.pc", exeMem.pc, expected.mem.pc);
            checkValue("exeMem.instr", exeMem.instr, expected.mem.instr);
            checkValue("exeMem.wbSel", exeMem.wbSel, expected.mem.wbSel);
            checkValue("exeMem.regsWr", exeMem.regsWr, expected.mem.regsWr);
            checkValue("exeMem.loadType", exeMem.loadType, expected.mem.loadType);
            checkValue("exeMem.storeType", exeMem.storeType, expected.mem.storeType);
            checkValue("exeMem.except", exeMem.except, expected.mem.except);
            checkValue("isTaken", isTaken, expected.taken);
            checkValue("predictionFailed", predictionFailed, expected.predFail);
            checkValue("correctionVector", correctionVector, expected.corr);
            checkValue("multDivStall", multDivStall, 1'b0);
        end else if (checkMode == 2) begin
            checkValue("exeMem.regsWr", exeMem.regsWr, 3'd0);
            checkValue("exeMem.loadType", exeMem.loadType, ldNone);
            checkValue("exeMem.storeType", exeMem.storeType, stNone);
            checkValue("exeMem.except", exeMem.except, 6'd0);
            checkValue("isTaken", isTaken, 1'b0);
            checkValue("predictionFailed", predictionFailed, 1'b0);
            checkValue("multDivStall", multDivStall, 1'b0);
        end
        checkMode = 0;
    end

    task automatic applyInstr(input IdExeBus ins, input bit flush);
        @(posedge clk);
        idExe    <= ins;
        exeWr    <= 1'b1;
        exeFlush <= flush;
        @(posedge clk);   // capture edge commits the previous mthi/mtlo too
        exeWr    <= 1'b0;
        exeFlush <= 1'b0;
        if (pendHi)
            shadowHi = pendData;
        if (pendLo)
            shadowLo = pendData;
        pendHi   = !flush && ins.regsWr.hiWr;
        pendLo   = !flush && ins.regsWr.loWr;
        pendData = ins.busA;
        expected = refExe(ins, shadowHi, shadowLo);
        checkMode = flush ? 2 : 1;
    endtask

    task automatic runMultDiv(input AluOp op, input logic [31:0] a, input logic [31:0] b);
        IdExeBus s;
        int      waited;
        s = randomInstr(0);
        s.aluOp     = op;
        s.busA      = a;
        s.busB      = b;
        s.regsWr    = '0;
        s.loadType  = ldNone;
        s.storeType = stNone;
        applyInstr(s, 0);
        checkMode = 0;   // aluOut of a mult/div is a don't care
        @(negedge clk);
        checkValue("multDivStall", multDivStall, 1'b1);
        waited = 0;
        while (multDivStall) begin
            if (waited > `DIV_CYCLES + 4) begin
                $display("multDivStall never dropped after a mult/div start");
                $display("ERRORS FOUND");
                $fatal(1);
            end
            @(negedge clk);
            waited++;
        end
        {shadowHi, shadowLo} = mdRef(op, a, b, shadowHi, shadowLo);
        @(posedge clk);   // hiLo takes the result here
        exeFlush <= 1'b1;
        @(posedge clk);   // hazard unit retires the slot with a bubble
        exeFlush <= 1'b0;
        checkMode = 2;
    endtask

    task automatic moveToHiLo(input logic [31:0] value, input bit toHi);
        IdExeBus s;
        s = randomInstr(0);
        s.busA   = value;
        s.regsWr = toHi ? 3'b010 : 3'b001;
        applyInstr(s, 0);
    endtask

    task automatic readHiLo();
        IdExeBus s;
        s = randomInstr(0);
        s.regsReadSel = readHi;   // mfhi
        s.wbSel       = wbOutB;
        s.regsWr      = 3'b100;
        applyInstr(s, 0);
        s.regsReadSel = readLo;   // mflo
        applyInstr(s, 0);
    endtask

    initial begin
        AluOp mdOps[4];
        clk       = 1'b0;
        rstN      = 1'b0;
        exeFlush  = 1'b0;
        exeWr     = 1'b0;
        idExe     = '0;
        checkMode = 0;
        mdOps = '{aluMult, aluMultu, aluDiv, aluDivu};
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        checkMode = 2;   // stage must come out of reset as a bubble
        repeat (300) applyInstr(randomInstr(0), 0);
        repeat (300) applyInstr(randomInstr(1), 0);
        repeat (20) applyInstr(randomInstr(1), 1);
        foreach (mdOps[i]) begin
            repeat (4) begin
                runMultDiv(mdOps[i], nextRand(), nextRand());
                readHiLo();
            end
            runMultDiv(mdOps[i], nextRand(), 32'd0);   // divide by zero
            readHiLo();
        end
        repeat (4) begin
            moveToHiLo(nextRand(), 1'b1);
            moveToHiLo(nextRand(), 1'b0);
            runMultDiv(aluMadd, nextRand(), nextRand());
            readHiLo();
        end
        repeat (2) @(posedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- verilog/exceptionInExe.sv
`timescale 1ns/1ps

module exceptionInExe (
    input  cpuPkg::ExceptType exceptIn,
    input  logic              overflow,
    input  cpuPkg::LoadType   loadType,
    input  cpuPkg::StoreType  storeType,
    input  logic [1:0]        addrLow,
    output cpuPkg::ExceptType except
);
    import cpuPkg::*;

    logic loadMisaligned;
    logic storeMisaligned;

    // word needs 4-byte alignment, half needs 2
    assign loadMisaligned  = ((loadType == ldWord) && (addrLow != 2'b00))
                             || ((loadType == ldHalf) && addrLow[0]);
    assign storeMisaligned = ((storeType == stWord) && (addrLow != 2'b00))
                             || ((storeType == stHalf) && addrLow[0]);

    always_comb begin
        except              = exceptIn;   // decode-stage flags pass through
        except.overflow     = exceptIn.overflow | overflow;
        except.addrErrLoad  = exceptIn.addrErrLoad | loadMisaligned;
        except.addrErrStore = exceptIn.addrErrStore | storeMisaligned;
    end

endmodule

//--- verilog/hiLo.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module hiLo (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   finish,
    input  logic                   accumulate,
    input  logic                   hiWr,
    input  logic                   loWr,
    input  logic [`DATA_WIDTH-1:0] writeData,
    input  logic [`DATA_WIDTH-1:0] multHi,
    input  logic [`DATA_WIDTH-1:0] multLo,
    output logic [`DATA_WIDTH-1:0] hi,
    output logic [`DATA_WIDTH-1:0] lo
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hi <= '0;
            lo <= '0;
        end else if (finish) begin
            if (accumulate)
                {hi, lo} <= {hi, lo} + {multHi, multLo};   // madd, 64-bit wrap
            else
                {hi, lo} <= {multHi, multLo};
        end else begin
            if (hiWr) hi <= writeData;
            if (loWr) lo <= writeData;
        end
    end

    // mthi in the slot of a finishing mult/div would be lost
    noWrOnFinish: assert property (
        @(posedge clk) disable iff (!rstN)
        !((hiWr || loWr) && finish)
    );

endmodule
